/* logic/fabric_macros.svh */
`ifndef FABRIC_MACROS_SVH
`define FABRIC_MACROS_SVH

// Two or more processor clusters
`define FABRIC_NUM_CLUSTERS 4

// Must cover FABRIC_NUM_CLUSTERS
`define FABRIC_CLUSTER_BITS 2

`define FABRIC_CORE_TAG_WIDTH 8
`define FABRIC_IO_ADDR_WIDTH 30
`define FABRIC_IO_DATA_WIDTH 32
`define FABRIC_CSR_ADDR_WIDTH 12

// Upper FABRIC_CLUSTER_BITS pick the cluster
`define FABRIC_CORE_ID_WIDTH 6

`endif

/* logic/fabric_pkg.sv */
`default_nettype none

`include "fabric_macros.svh"

package fabric_pkg;

    typedef logic [`FABRIC_IO_DATA_WIDTH-1:0] data_word_t;

    // Request as issued by one cluster
    typedef struct packed {
        logic                              rw;
        logic [3:0]                        byteen;
        logic [`FABRIC_IO_ADDR_WIDTH-1:0]  addr;
        data_word_t                        data;
        logic [`FABRIC_CORE_TAG_WIDTH-1:0] core_tag;
    } io_req_t;

    // Host side tag with the cluster index on top
    typedef struct packed {
        logic [`FABRIC_CLUSTER_BITS-1:0]   cluster;
        logic [`FABRIC_CORE_TAG_WIDTH-1:0] core_tag;
    } io_tag_t;

    typedef struct packed {
        logic                             rw;
        logic [3:0]                       byteen;
        logic [`FABRIC_IO_ADDR_WIDTH-1:0] addr;
        data_word_t                       data;
        io_tag_t                          tag;
    } io_out_req_t;

    typedef struct packed {
        data_word_t                        data;
        logic [`FABRIC_CORE_TAG_WIDTH-1:0] core_tag;
    } io_rsp_t;

    typedef struct packed {
        data_word_t data;
        io_tag_t    tag;
    } io_out_rsp_t;

    typedef struct packed {
        logic [`FABRIC_CSR_ADDR_WIDTH-1:0] addr;
        logic                              rw;
        data_word_t                        data;
    } csr_req_t;

endpackage

`default_nettype wire

/* logic/io_req_arb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fabric_macros.svh"

module io_req_arb (
    input  wire                                                 clk,
    input  wire                                                 reset,

    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                      cl_io_req_valid,
    input  wire fabric_pkg::io_req_t [`FABRIC_NUM_CLUSTERS-1:0] cl_io_req,
    output logic [`FABRIC_NUM_CLUSTERS-1:0]                     cl_io_req_ready,

    output logic                                                io_req_valid,
    output fabric_pkg::io_out_req_t                             io_req,
    input  wire                                                 io_req_ready
);
    import fabric_pkg::*;

    localparam int N = `FABRIC_NUM_CLUSTERS;

    typedef logic [`FABRIC_CLUSTER_BITS-1:0] cl_idx_t;

    cl_idx_t     last_grant;
    cl_idx_t     grant_idx;
    logic        grant_found;
    logic        can_accept;
    io_req_t     sel_req;
    io_out_req_t next_req;

    // Output register free now or draining this cycle
    assign can_accept = !io_req_valid || io_req_ready;

    // Search starts one past the last grant
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(last_grant) + k) % N;
            if (!grant_found && cl_io_req_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = cl_idx_t'(idx);
            end
        end
    end

    always_comb begin
        cl_io_req_ready = '0;
        if (can_accept && grant_found) begin
            cl_io_req_ready[grant_idx] = 1'b1;
        end
    end

    // Winner's tag gets its cluster index prepended
    always_comb begin
        sel_req               = cl_io_req[grant_idx];
        next_req.rw           = sel_req.rw;
        next_req.byteen       = sel_req.byteen;
        next_req.addr         = sel_req.addr;
        next_req.data         = sel_req.data;
        next_req.tag.cluster  = grant_idx;
        next_req.tag.core_tag = sel_req.core_tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            io_req_valid <= 1'b0;
            last_grant   <= cl_idx_t'(N - 1);
        end else if (can_accept) begin
            io_req_valid <= grant_found;
            if (grant_found) begin
                last_grant <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_accept && grant_found) begin
            io_req <= next_req;
        end
    end

endmodule

`default_nettype wire

/* logic/io_rsp_router.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fabric_macros.svh"

module io_rsp_router (
    input  wire                                                   io_rsp_valid,
    input  wire fabric_pkg::io_out_rsp_t                          io_rsp,
    output logic                                                  io_rsp_ready,

    output logic [`FABRIC_NUM_CLUSTERS-1:0]                       cl_io_rsp_valid,
    output fabric_pkg::io_rsp_t [`FABRIC_NUM_CLUSTERS-1:0]        cl_io_rsp,
    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                        cl_io_rsp_ready
);
    import fabric_pkg::*;

    io_rsp_t rsp_stripped;

    // Cluster field dropped, core tag kept
    assign rsp_stripped.data     = io_rsp.data;
    assign rsp_stripped.core_tag = io_rsp.tag.core_tag;

    always_comb begin
        cl_io_rsp_valid = '0;
        cl_io_rsp_valid[io_rsp.tag.cluster] = io_rsp_valid;
    end

    assign io_rsp_ready = cl_io_rsp_ready[io_rsp.tag.cluster];

    // Payload goes to all, valid picks the one
    for (genvar i = 0; i < `FABRIC_NUM_CLUSTERS; i++) begin : g_rsp
        assign cl_io_rsp[i] = rsp_stripped;
    end

endmodule

`default_nettype wire

/* logic/csr_io_router.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fabric_macros.svh"

module csr_io_router (
    input  wire                                              clk,
    input  wire                                              reset,

    input  wire                                              csr_io_req_valid,
    input  wire [`FABRIC_CORE_ID_WIDTH-1:0]                  csr_io_req_coreid,
    input  wire fabric_pkg::csr_req_t                        csr_io_req,
    output logic                                             csr_io_req_ready,

    output logic [`FABRIC_NUM_CLUSTERS-1:0]                  cl_csr_req_valid,
    output fabric_pkg::csr_req_t                             cl_csr_req,
    output logic [`FABRIC_CORE_ID_WIDTH-`FABRIC_CLUSTER_BITS-1:0] cl_csr_coreid,
    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                   cl_csr_req_ready,

    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                   cl_csr_rsp_valid,
    input  wire fabric_pkg::data_word_t [`FABRIC_NUM_CLUSTERS-1:0] cl_csr_rsp_data,
    output logic [`FABRIC_NUM_CLUSTERS-1:0]                  cl_csr_rsp_ready,

    output logic                                             csr_io_rsp_valid,
    output fabric_pkg::data_word_t                           csr_io_rsp_data,
    input  wire                                              csr_io_rsp_ready
);
    import fabric_pkg::*;

    localparam int CB  = `FABRIC_CLUSTER_BITS;
    localparam int LOW = `FABRIC_CORE_ID_WIDTH - `FABRIC_CLUSTER_BITS;

    typedef enum logic [1:0] {
        state_idle,
        state_issue,
        state_wait
    } state_t;

    state_t         state;
    csr_req_t       req_reg;
    logic [CB-1:0]  target;
    logic [LOW-1:0] coreid_low;
    logic           req_fire;

    assign csr_io_req_ready = (state == state_idle);
    assign req_fire         = csr_io_req_valid && csr_io_req_ready;

    assign cl_csr_req    = req_reg;
    assign cl_csr_coreid = coreid_low;

    // Only the target cluster sees valid or ready
    always_comb begin
        cl_csr_req_valid = '0;
        cl_csr_rsp_ready = '0;
        cl_csr_req_valid[target] = (state == state_issue);
        cl_csr_rsp_ready[target] = (state == state_wait) && csr_io_rsp_ready;
    end

    assign csr_io_rsp_valid = (state == state_wait) && cl_csr_rsp_valid[target];
    assign csr_io_rsp_data  = cl_csr_rsp_data[target];

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= state_idle;
            target <= '0;
        end else begin
            case (state)
                state_idle: begin
                    if (req_fire) begin
                        state  <= state_issue;
                        target <= csr_io_req_coreid[`FABRIC_CORE_ID_WIDTH-1 -: CB];
                    end
                end
                state_issue: begin
                    if (cl_csr_req_ready[target]) begin
                        state <= state_wait;
                    end
                end
                state_wait: begin
                    if (csr_io_rsp_valid && csr_io_rsp_ready) begin
                        state <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_reg    <= csr_io_req;
            coreid_low <= csr_io_req_coreid[LOW-1:0];
        end
    end

endmodule

`default_nettype wire

/* logic/cluster_fabric.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fabric_macros.svh"

module cluster_fabric (
    input  wire                                                   clk,
    input  wire                                                   reset,

    // Cluster I/O requests
    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                        cl_io_req_valid,
    input  wire fabric_pkg::io_req_t [`FABRIC_NUM_CLUSTERS-1:0]   cl_io_req,
    output logic [`FABRIC_NUM_CLUSTERS-1:0]                       cl_io_req_ready,

    // Host I/O request
    output logic                                                  io_req_valid,
    output fabric_pkg::io_out_req_t                               io_req,
    input  wire                                                   io_req_ready,

    // Host I/O response
    input  wire                                                   io_rsp_valid,
    input  wire fabric_pkg::io_out_rsp_t                          io_rsp,
    output logic                                                  io_rsp_ready,

    // Cluster I/O responses
    output logic [`FABRIC_NUM_CLUSTERS-1:0]                       cl_io_rsp_valid,
    output fabric_pkg::io_rsp_t [`FABRIC_NUM_CLUSTERS-1:0]        cl_io_rsp,
    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                        cl_io_rsp_ready,

    // Host CSR port
    input  wire                                                   csr_io_req_valid,
    input  wire [`FABRIC_CORE_ID_WIDTH-1:0]                       csr_io_req_coreid,
    input  wire fabric_pkg::csr_req_t                             csr_io_req,
    output logic                                                  csr_io_req_ready,
    output logic                                                  csr_io_rsp_valid,
    output fabric_pkg::data_word_t                                csr_io_rsp_data,
    input  wire                                                   csr_io_rsp_ready,

    // Cluster CSR ports
    output logic [`FABRIC_NUM_CLUSTERS-1:0]                       cl_csr_req_valid,
    output fabric_pkg::csr_req_t                                  cl_csr_req,
    output logic [`FABRIC_CORE_ID_WIDTH-`FABRIC_CLUSTER_BITS-1:0] cl_csr_coreid,
    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                        cl_csr_req_ready,
    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                        cl_csr_rsp_valid,
    input  wire fabric_pkg::data_word_t [`FABRIC_NUM_CLUSTERS-1:0] cl_csr_rsp_data,
    output logic [`FABRIC_NUM_CLUSTERS-1:0]                       cl_csr_rsp_ready,

    // Status
    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                        cl_busy,
    input  wire [`FABRIC_NUM_CLUSTERS-1:0]                        cl_ebreak,
    output logic                                                  busy,
    output logic                                                  ebreak
);

    io_req_arb u_io_req_arb (
        .clk             (clk),
        .reset           (reset),
        .cl_io_req_valid (cl_io_req_valid),
        .cl_io_req       (cl_io_req),
        .cl_io_req_ready (cl_io_req_ready),
        .io_req_valid    (io_req_valid),
        .io_req          (io_req),
        .io_req_ready    (io_req_ready)
    );

    io_rsp_router u_io_rsp_router (
        .io_rsp_valid    (io_rsp_valid),
        .io_rsp          (io_rsp),
        .io_rsp_ready    (io_rsp_ready),
        .cl_io_rsp_valid (cl_io_rsp_valid),
        .cl_io_rsp       (cl_io_rsp),
        .cl_io_rsp_ready (cl_io_rsp_ready)
    );

    csr_io_router u_csr_io_router (
        .clk               (clk),
        .reset             (reset),
        .csr_io_req_valid  (csr_io_req_valid),
        .csr_io_req_coreid (csr_io_req_coreid),
        .csr_io_req        (csr_io_req),
        .csr_io_req_ready  (csr_io_req_ready),
        .cl_csr_req_valid  (cl_csr_req_valid),
        .cl_csr_req        (cl_csr_req),
        .cl_csr_coreid     (cl_csr_coreid),
        .cl_csr_req_ready  (cl_csr_req_ready),
        .cl_csr_rsp_valid  (cl_csr_rsp_valid),
        .cl_csr_rsp_data   (cl_csr_rsp_data),
        .cl_csr_rsp_ready  (cl_csr_rsp_ready),
        .csr_io_rsp_valid  (csr_io_rsp_valid),
        .csr_io_rsp_data   (csr_io_rsp_data),
        .csr_io_rsp_ready  (csr_io_rsp_ready)
    );

    // Any cluster busy, all clusters halted
    assign busy   = |cl_busy;
    assign ebreak = &cl_ebreak;

endmodule

`default_nettype wire

/* testbench/fabric_checks.svh */
int io_errors   = 0;
int csr_errors  = 0;
int flag_errors = 0;

task automatic check_io_req(input string name, input io_out_req_t exp, input io_out_req_t act);
    if (act !== exp) begin
        io_errors++;
        $display("ERROR %s: io_req expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_io_rsp(input string name, input int cl, input io_rsp_t exp,
                            input io_rsp_t act);
    if (act !== exp) begin
        io_errors++;
        $display("ERROR %s: cl_io_rsp[%0d] expected %h actual %h", name, cl, exp, act);
    end
endtask

task automatic check_csr(input string name, input int cl, input data_word_t exp,
                         input data_word_t act);
    if (act !== exp) begin
        csr_errors++;
        $display("ERROR %s: rsp data of cluster %0d expected %h actual %h", name, cl, exp, act);
    end
endtask

// Request payload and low core id as one value
task automatic check_csr_req(input string name, input csr_req_t exp, input logic [LOW-1:0] exp_id,
                             input csr_req_t act, input logic [LOW-1:0] act_id);
    if ({act, act_id} !== {exp, exp_id}) begin
        csr_errors++;
        $display("ERROR %s: csr req expected %h actual %h", name, {exp, exp_id}, {act, act_id});
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        flag_errors++;
        $display("ERROR %s: flag expected %b actual %b", name, exp, act);
    end
endtask

task automatic check_vec(input string name, input logic [N-1:0] exp, input logic [N-1:0] act);
    if (act !== exp) begin
        flag_errors++;
        $display("ERROR %s: bit vector expected %b actual %b", name, exp, act);
    end
endtask

/* testbench/fabric_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fabric_macros.svh"

module fabric_tb;
    import fabric_pkg::*;

    localparam int N   = `FABRIC_NUM_CLUSTERS;
    localparam int LOW = `FABRIC_CORE_ID_WIDTH - `FABRIC_CLUSTER_BITS;
    localparam int NT  = 12;
    // 20 cycles per table entry plus reset
    localparam int CYCLE_LIMIT = NT * 20 + 12;

    typedef enum {K_IO_REQ, K_IO_ALL, K_IO_RSP, K_CSR, K_STATUS} kind_t;

    typedef struct {
        string        name;
        kind_t        kind;
        int           arg;    // cluster, or full core id for CSR
        int           stall;
        logic [N-1:0] busy_pat;
        logic [N-1:0] ebreak_pat;
        logic         exp_busy;
        logic         exp_ebreak;
    } test_t;

    logic         clk = 1'b0;
    logic         reset;
    logic         io_req_valid, io_req_ready, io_rsp_valid, io_rsp_ready;
    logic         csr_io_req_valid, csr_io_req_ready, csr_io_rsp_valid, csr_io_rsp_ready;
    logic         busy, ebreak;
    logic [N-1:0] cl_io_req_valid, cl_io_req_ready, cl_io_rsp_valid, cl_io_rsp_ready;
    logic [N-1:0] cl_csr_req_valid, cl_csr_req_ready, cl_csr_rsp_valid, cl_csr_rsp_ready;
    logic [N-1:0] cl_busy, cl_ebreak;
    logic [`FABRIC_CORE_ID_WIDTH-1:0] csr_io_req_coreid;
    logic [LOW-1:0]      cl_csr_coreid;
    io_req_t     [N-1:0] cl_io_req;
    io_rsp_t     [N-1:0] cl_io_rsp;
    data_word_t  [N-1:0] cl_csr_rsp_data;
    io_out_req_t io_req;
    io_out_rsp_t io_rsp;
    csr_req_t    csr_io_req, cl_csr_req;
    data_word_t  csr_io_rsp_data;
    integer      seed = 32'heb051cad;
    int          cycles = 0;
    test_t       tests [NT];

    `include "fabric_checks.svh"

    cluster_fabric dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic io_req_t rand_req();
        logic [95:0] bits;
        bits = {$random(seed), $random(seed), $random(seed)};
        return bits[$bits(io_req_t)-1:0];
    endfunction

    // Host side form keeps the fields and puts the cluster index above the core tag
    function automatic io_out_req_t with_cluster_tag(io_req_t r, int c);
        io_out_req_t o;
        o.rw           = r.rw;
        o.byteen       = r.byteen;
        o.addr         = r.addr;
        o.data         = r.data;
        o.tag.cluster  = c[`FABRIC_CLUSTER_BITS-1:0];
        o.tag.core_tag = r.core_tag;
        return o;
    endfunction

    task automatic drive_single_req(string name, int c, int stall);
        io_req_t      r;
        io_out_req_t  exp;
        logic [N-1:0] onehot;
        r         = rand_req();
        exp       = with_cluster_tag(r, c);
        onehot    = '0;
        onehot[c] = 1'b1;
        @(posedge clk);
        cl_io_req[c]       <= r;
        cl_io_req_valid[c] <= 1'b1;
        do @(negedge clk); while (!cl_io_req_ready[c]);
        check_vec(name, onehot, cl_io_req_ready);
        check_flag(name, 1'b0, io_req_valid);
        @(posedge clk);
        cl_io_req_valid <= '0;
        // Must hold through back-pressure
        repeat (stall + 1) begin
            @(negedge clk);
            check_flag(name, 1'b1, io_req_valid);
            check_io_req(name, exp, io_req);
        end
        @(posedge clk);
        io_req_ready <= 1'b1;
        @(posedge clk);
        io_req_ready <= 1'b0;
        @(negedge clk);
        check_flag(name, 1'b0, io_req_valid);
    endtask

    task automatic sweep_all_clusters(string name);
        io_req_t [N-1:0] reqs;
        logic [N-1:0]    seen;
        int              prev;
        int              c;
        int              n;
        for (int i = 0; i < N; i++) begin
            reqs[i] = rand_req();
        end
        seen = '0;
        prev = -1;
        n    = 0;
        @(posedge clk);
        cl_io_req       <= reqs;
        cl_io_req_valid <= '1;
        io_req_ready    <= 1'b1;
        // Requests stay up, so every output has to come from a new cluster
        while (n < N) begin
            @(negedge clk);
            if (io_req_valid) begin
                c = int'(io_req.tag.cluster);
                if (seen[c] || c == prev) begin
                    io_errors++;
                    $display("%s: cluster %0d was granted again before the others", name, c);
                end
                check_io_req(name, with_cluster_tag(reqs[c], c), io_req);
                seen[c] = 1'b1;
                prev    = c;
                n++;
            end
            @(posedge clk);
        end
        cl_io_req_valid <= '0;
        @(posedge clk);
        io_req_ready <= 1'b0;
        @(negedge clk);
        check_flag(name, 1'b0, io_req_valid);
    endtask

    task automatic route_response(string name, int c);
        logic [63:0]  bits;
        io_out_rsp_t  rsp;
        io_rsp_t      exp;
        logic [N-1:0] rdy;
        logic [N-1:0] onehot;
        bits            = {$random(seed), $random(seed)};
        rsp             = bits[$bits(io_out_rsp_t)-1:0];
        rsp.tag.cluster = c[`FABRIC_CLUSTER_BITS-1:0];
        rdy             = bits[63 -: N];
        exp.data        = rsp.data;
        exp.core_tag    = rsp.tag.core_tag;
        onehot          = '0;
        onehot[c]       = 1'b1;
        // Second pass flips the addressed cluster's ready
        for (int pass = 0; pass < 2; pass++) begin
            @(posedge clk);
            io_rsp          <= rsp;
            io_rsp_valid    <= 1'b1;
            cl_io_rsp_ready <= rdy;
            @(negedge clk);
            check_vec(name, onehot, cl_io_rsp_valid);
            check_io_rsp(name, c, exp, cl_io_rsp[c]);
            check_flag(name, rdy[c], io_rsp_ready);
            rdy = rdy ^ onehot;
        end
        @(posedge clk);
        io_rsp_valid <= 1'b0;
    endtask

    task automatic csr_round_trip(string name, int id);
        logic [63:0]  bits;
        logic [`FABRIC_CORE_ID_WIDTH-1:0] coreid;
        csr_req_t     req;
        data_word_t   data_k;
        data_word_t   data_o;
        logic [N-1:0] onehot;
        int           k;
        int           other;
        bits      = {$random(seed), $random(seed)};
        req       = bits[$bits(csr_req_t)-1:0];
        data_k    = $random(seed);
        data_o    = $random(seed);
        coreid    = id[`FABRIC_CORE_ID_WIDTH-1:0];
        k         = int'(coreid[`FABRIC_CORE_ID_WIDTH-1 -: `FABRIC_CLUSTER_BITS]);
        other     = (k + 1) % N;
        onehot    = '0;
        onehot[k] = 1'b1;
        @(posedge clk);
        csr_io_req_valid  <= 1'b1;
        csr_io_req_coreid <= coreid;
        csr_io_req        <= req;
        do @(negedge clk); while (!csr_io_req_ready);
        @(posedge clk);
        csr_io_req_valid <= 1'b0;
        do begin
            @(negedge clk);
            check_flag(name, 1'b0, csr_io_req_ready);
        end while (cl_csr_req_valid == '0);
        check_vec(name, onehot, cl_csr_req_valid);
        check_csr_req(name, req, coreid[LOW-1:0], cl_csr_req, cl_csr_coreid);
        // Target accepts one cycle late
        @(posedge clk);
        cl_csr_req_ready[k] <= 1'b1;
        @(posedge clk);
        cl_csr_req_ready        <= '0;
        cl_csr_rsp_valid[other] <= 1'b1;
        cl_csr_rsp_data[other]  <= data_o;
        csr_io_rsp_ready        <= 1'b1;
        @(negedge clk);
        check_flag(name, 1'b0, csr_io_rsp_valid);
        check_flag(name, 1'b0, cl_csr_rsp_ready[other]);
        check_flag(name, 1'b0, csr_io_req_ready);
        @(posedge clk);
        cl_csr_rsp_valid[k] <= 1'b1;
        cl_csr_rsp_data[k]  <= data_k;
        @(negedge clk);
        check_flag(name, 1'b1, csr_io_rsp_valid);
        check_flag(name, 1'b1, cl_csr_rsp_ready[k]);
        check_csr(name, k, data_k, csr_io_rsp_data);
        @(posedge clk);
        cl_csr_rsp_valid <= '0;
        csr_io_rsp_ready <= 1'b0;
        @(negedge clk);
        check_flag(name, 1'b1, csr_io_req_ready);
    endtask

    task automatic apply_status(test_t t);
        @(posedge clk);
        cl_busy   <= t.busy_pat;
        cl_ebreak <= t.ebreak_pat;
        @(negedge clk);
        check_flag(t.name, t.exp_busy, busy);
        check_flag(t.name, t.exp_ebreak, ebreak);
    endtask

    initial begin
        reset             = 1'b1;
        cl_io_req_valid   = '0;
        cl_io_req         = '0;
        io_req_ready      = 1'b0;
        io_rsp_valid      = 1'b0;
        io_rsp            = '0;
        cl_io_rsp_ready   = '0;
        csr_io_req_valid  = 1'b0;
        csr_io_req_coreid = '0;
        csr_io_req        = '0;
        csr_io_rsp_ready  = 1'b0;
        cl_csr_req_ready  = '0;
        cl_csr_rsp_valid  = '0;
        cl_csr_rsp_data   = '0;
        cl_busy           = '0;
        cl_ebreak         = '0;

        tests[0]  = '{"io_req_c0", K_IO_REQ, 0, 0, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[1]  = '{"io_req_c2_stall", K_IO_REQ, 2, 3, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[2]  = '{"io_req_c3_stall", K_IO_REQ, 3, 1, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[3]  = '{"io_req_all", K_IO_ALL, 0, 0, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[4]  = '{"io_rsp_c1", K_IO_RSP, 1, 0, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[5]  = '{"io_rsp_c3", K_IO_RSP, 3, 0, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[6]  = '{"csr_core_05", K_CSR, 'h05, 0, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[7]  = '{"csr_core_2a", K_CSR, 'h2a, 0, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[8]  = '{"csr_core_3f", K_CSR, 'h3f, 0, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[9]  = '{"status_idle", K_STATUS, 0, 0, 4'b0000, 4'b0000, 1'b0, 1'b0};
        tests[10] = '{"status_all_halt", K_STATUS, 0, 0, 4'b0100, 4'b1111, 1'b1, 1'b1};
        tests[11] = '{"status_mixed", K_STATUS, 0, 0, 4'b1011, 4'b0111, 1'b1, 1'b0};

        repeat (10) begin
            @(negedge clk);
            check_flag("reset", 1'b0, io_req_valid);
            check_vec("reset", '0, cl_csr_req_valid);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("after_reset", 1'b0, io_req_valid);
        check_vec("after_reset", '0, cl_csr_req_valid);
        check_flag("after_reset", 1'b0, csr_io_rsp_valid);
        @(negedge clk);
        check_flag("after_reset", 1'b1, csr_io_req_ready);

        for (int i = 0; i < NT; i++) begin
            case (tests[i].kind)
                K_IO_REQ: drive_single_req(tests[i].name, tests[i].arg, tests[i].stall);
                K_IO_ALL: sweep_all_clusters(tests[i].name);
                K_IO_RSP: route_response(tests[i].name, tests[i].arg);
                K_CSR:    csr_round_trip(tests[i].name, tests[i].arg);
                default:  apply_status(tests[i]);
            endcase
        end

        $display("io errors %0d, csr errors %0d, flag errors %0d",
                 io_errors, csr_errors, flag_errors);
        if (io_errors + csr_errors + flag_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
+incdir+testbench
logic/fabric_pkg.sv
logic/io_req_arb.sv
logic/io_rsp_router.sv
logic/csr_io_router.sv
logic/cluster_fabric.sv
testbench/fabric_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = fabric_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Pass only when the exact pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
